// ==== verilog.f ====
McbPkg.sv
SyncFifoController.sv
UfiBridge.sv
UsiMasterPort.sv
MicroControllerCsr.sv
MicroControllerBlock.sv
tb_MicroControllerBlock.sv

// ==== Makefile ====
# Verilator simulation of the system management block

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_MicroControllerBlock
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== tb_MicroControllerBlock.sv ====
/*
 * Testbench for the system management block
 * Exercises the host port, the CSR, the cache memory drain and the UFI
 * read capture, with a queue model of the cache memory
 */
`timescale 1ns/100ps

module tb_MicroControllerBlock;

	localparam int         CacheDepth    = 512;
	localparam int         TimeoutCycles = 2000;
	localparam logic [7:0] OwnBlk        = McbPkg::McbBlockAdrs;
	localparam logic [7:0] OtherBlk      = 8'h02;

	logic              iSCLK;
	logic              iSRST;
	McbPkg::usiWord_t  iSUsiWd;
	McbPkg::usiWord_t  iSUsiAdrs;
	McbPkg::usiWord_t  oSUsiRd;
	McbPkg::usiWord_t  iMUsiRd;
	McbPkg::usiWord_t  oMUsiWd;
	McbPkg::usiWord_t  oMUsiAdrs;
	McbPkg::ufiDq_t    iMUfiRd;
	McbPkg::ufiAdrs_t  iMUfiAdrs;
	McbPkg::ufiDq_t    oMUfiWd;
	McbPkg::ufiAdrs_t  oMUfiAdrs;
	logic              iMUfiRdy;
	McbPkg::usiWord_t  iHostWd;
	logic              iHostWdEn;
	logic              iHostAdrsEn;
	McbPkg::usiWord_t  oHostRd;

	// Pending cache entries, 31 address bits above 16 data bits
	logic [46:0] cacheModel [$];
	logic [31:0] rngState;
	logic        rdySeen;
	int          errCnt    = 0;
	int          checkCnt  = 0;
	int          testFails = 0;

	MicroControllerBlock MicroControllerBlock_i (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.iSUsiWd     (iSUsiWd),
		.iSUsiAdrs   (iSUsiAdrs),
		.oSUsiRd     (oSUsiRd),
		.iMUsiRd     (iMUsiRd),
		.oMUsiWd     (oMUsiWd),
		.oMUsiAdrs   (oMUsiAdrs),
		.iMUfiRd     (iMUfiRd),
		.iMUfiAdrs   (iMUfiAdrs),
		.oMUfiWd     (oMUfiWd),
		.oMUfiAdrs   (oMUfiAdrs),
		.iMUfiRdy    (iMUfiRdy),
		.iHostWd     (iHostWd),
		.iHostWdEn   (iHostWdEn),
		.iHostAdrsEn (iHostAdrsEn),
		.oHostRd     (oHostRd)
	);

	always #20 iSCLK = ~iSCLK;

	//------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	task automatic checkEq(input string sig, input logic [47:0] act, input logic [47:0] exp);
		checkCnt++;
		assert (act === exp)
		else
		begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", sig, act, exp);
			errCnt++;
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checkCnt++;
		assert (cond === 1'b1)
		else
		begin
			$display("%s", what);
			errCnt++;
		end
	endtask

	// One access, read data is checked in the cycle after
	task automatic csrAccess(input logic [7:0] blk, input McbPkg::csrAdrs_t ofs,
		input logic [31:0] wd, input logic [31:0] expRd);
		@(posedge iSCLK);
		iSUsiAdrs <= {blk, 16'h0000, ofs};
		iSUsiWd   <= wd;
		@(posedge iSCLK);
		iSUsiAdrs <= '0;
		iSUsiWd   <= '0;
		@(negedge iSCLK);
		checkEq("oSUsiRd", oSUsiRd, expRd);
	endtask

	task automatic pushEntry(input logic [31:0] dataWord, input logic [31:0] adrsWord,
		input int holdCycles);
		csrAccess(OwnBlk, McbPkg::CsrRamWd, dataWord, {16'h0, dataWord[15:0]});
		csrAccess(OwnBlk, McbPkg::CsrRamAdrs, adrsWord, {1'b0, adrsWord[30:0]});
		csrAccess(OwnBlk, McbPkg::CsrRamEn, 32'h1, 32'h1);
		repeat (holdCycles) @(posedge iSCLK);
		csrAccess(OwnBlk, McbPkg::CsrRamEn, 32'h0, 32'h0);
		// A write into a full cache is dropped
		if (cacheModel.size() < CacheDepth)
			cacheModel.push_back({adrsWord[30:0], dataWord[15:0]});
	endtask

	task automatic drainCache();
		int cycles;
		cycles = 0;
		@(posedge iSCLK);
		iMUfiRdy <= 1'b1;
		while (cacheModel.size() != 0 && cycles < TimeoutCycles)
		begin
			@(posedge iSCLK);
			cycles++;
		end
		checkTrue(cacheModel.size() == 0, "Timeout waiting for the cache to drain");
		iMUfiRdy <= 1'b0;
		csrAccess(OwnBlk, McbPkg::CsrStatus, 32'h0, 32'h2);
	endtask

	task automatic reportTest(input int num, input string name, input int errBefore);
		if (errCnt == errBefore)
			$display("Test %0d %s: passed", num, name);
		else
		begin
			$display("Test %0d %s: failed with %0d errors", num, name, errCnt - errBefore);
			testFails++;
		end
	endtask

	//------------------------------------------------------------
	// UFI drain monitor
	//------------------------------------------------------------
	// Ready level the DUT saw at the edge that issued the read
	always @(posedge iSCLK)
		rdySeen <= iMUfiRdy;

	// Each valid beat must match the oldest modelled entry
	always @(negedge iSCLK)
	begin
		if (oMUfiAdrs[31] === 1'b1)
		begin
			checkTrue(rdySeen, "Valid beat on the UFI bus while ready was low");
			if (cacheModel.size() == 0)
				checkTrue(1'b0, "Valid beat on the UFI bus with no entry left in the model");
			else
			begin
				checkEq("oMUfiWd", oMUfiWd, cacheModel[0][15:0]);
				checkEq("oMUfiAdrs[30:0]", oMUfiAdrs[30:0], cacheModel[0][46:16]);
				void'(cacheModel.pop_front());
			end
		end
	end

	//------------------------------------------------------------
	// Tests
	//------------------------------------------------------------
	task automatic hostPortTest();
		logic [31:0] hostWord;
		logic [31:0] adrsWord;
		logic [31:0] busWord;
		@(negedge iSCLK);
		checkEq("oSUsiRd", oSUsiRd, 48'h0);
		checkEq("oMUsiWd", oMUsiWd, 48'h0);
		checkEq("oMUsiAdrs", oMUsiAdrs, 48'h0);
		checkEq("oMUfiWd", oMUfiWd, 48'h0);
		checkEq("oMUfiAdrs", oMUfiAdrs, 48'h0);
		checkEq("oHostRd", oHostRd, 48'h0);
		csrAccess(OwnBlk, McbPkg::CsrStatus, 32'h0, 32'h2);
		// Write data strobe, then the value holds
		hostWord = nextRand();
		@(posedge iSCLK);
		iHostWd   <= hostWord;
		iHostWdEn <= 1'b1;
		@(posedge iSCLK);
		iHostWdEn <= 1'b0;
		iHostWd   <= ~hostWord;
		@(negedge iSCLK);
		checkEq("oMUsiWd", oMUsiWd, hostWord);
		repeat (3) @(posedge iSCLK);
		@(negedge iSCLK);
		checkEq("oMUsiWd", oMUsiWd, hostWord);
		// Address strobe lasts one cycle
		adrsWord = nextRand();
		@(posedge iSCLK);
		iHostWd     <= adrsWord;
		iHostAdrsEn <= 1'b1;
		@(posedge iSCLK);
		iHostAdrsEn <= 1'b0;
		@(negedge iSCLK);
		checkEq("oMUsiAdrs", oMUsiAdrs, adrsWord);
		@(negedge iSCLK);
		checkEq("oMUsiAdrs", oMUsiAdrs, 48'h0);
		checkEq("oMUsiWd", oMUsiWd, hostWord);
		busWord = nextRand();
		@(posedge iSCLK);
		iMUsiRd <= busWord;
		@(negedge iSCLK);
		checkEq("oHostRd", oHostRd, busWord);
	endtask

	task automatic regAccessTest();
		logic [31:0] dataWord;
		logic [31:0] adrsWord;
		logic [31:0] junkWord;
		dataWord = nextRand() | 32'hFFFF_0000;
		adrsWord = nextRand() | 32'h8000_0000;
		junkWord = nextRand();
		csrAccess(OwnBlk, McbPkg::CsrRamWd, dataWord, {16'h0, dataWord[15:0]});
		csrAccess(OwnBlk, McbPkg::CsrRamAdrs, adrsWord, {1'b0, adrsWord[30:0]});
		// Another block field, read data and registers stay put
		csrAccess(OtherBlk, McbPkg::CsrRamWd, junkWord, {1'b0, adrsWord[30:0]});
		csrAccess(OtherBlk, McbPkg::CsrRamEn, 32'h1, {1'b0, adrsWord[30:0]});
		csrAccess(OwnBlk, McbPkg::CsrStatus, 32'h0, 32'h2);
		// Enable alone, the entry shows what the registers kept
		csrAccess(OwnBlk, McbPkg::CsrRamEn, 32'h1, 32'h1);
		csrAccess(OwnBlk, McbPkg::CsrRamEn, 32'h0, 32'h0);
		cacheModel.push_back({adrsWord[30:0], dataWord[15:0]});
		drainCache();
	endtask

	task automatic cacheOrderTest();
		for (int n = 0; n < 8; n++)
			pushEntry(nextRand(), nextRand(), (n == 3) ? 6 : 0);
		// Not empty, not full
		csrAccess(OwnBlk, McbPkg::CsrStatus, 32'h0, 32'h0);
		drainCache();
	endtask

	task automatic backPressureTest();
		int cycles;
		cycles = 0;
		for (int n = 0; n < 20; n++)
			pushEntry(nextRand(), nextRand(), 0);
		@(posedge iSCLK);
		iMUfiRdy <= 1'b1;
		while (cacheModel.size() > 12 && cycles < TimeoutCycles)
		begin
			@(posedge iSCLK);
			cycles++;
		end
		checkTrue(cacheModel.size() <= 12, "Timeout waiting for the drain to start");
		iMUfiRdy <= 1'b0;
		// Pause long enough for a stray beat to show
		repeat (16) @(posedge iSCLK);
		checkTrue(cacheModel.size() > 0, "Cache drained completely while ready was low");
		drainCache();
	endtask

	task automatic fullTest();
		for (int n = 0; n < CacheDepth + 3; n++)
			pushEntry(nextRand(), nextRand(), 0);
		csrAccess(OwnBlk, McbPkg::CsrStatus, 32'h0, 32'h1);
		drainCache();
	endtask

	task automatic ufiCaptureTest();
		logic [31:0] adrsWord;
		logic [31:0] rdWord;
		logic [15:0] lastRd;
		int          capCnt;
		lastRd = 16'h0;
		capCnt = 0;
		// Matching, foreign map, and bit 31 low in turn
		for (int n = 0; n < 12; n++)
		begin
			adrsWord        = nextRand();
			rdWord          = nextRand();
			adrsWord[31]    = (n % 3 != 2);
			adrsWord[28:25] = (n % 3 == 1) ? ~McbPkg::McbUfiAdrsMap : McbPkg::McbUfiAdrsMap;
			@(posedge iSCLK);
			iMUfiAdrs <= adrsWord;
			iMUfiRd   <= rdWord[15:0];
			@(posedge iSCLK);
			iMUfiAdrs <= '0;
			// Only the first of each three is aimed at this block
			if (n % 3 == 0)
			begin
				lastRd = rdWord[15:0];
				capCnt++;
			end
		end
		csrAccess(OwnBlk, McbPkg::CsrUfiRd, 32'h0, {16'h0, lastRd});
		csrAccess(OwnBlk, McbPkg::CsrUfiRdCnt, 32'h0, 32'(capCnt));
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial
	begin
		int errBefore;
		iSCLK       = 1'b0;
		iSRST       = 1'b1;
		iSUsiWd     = '0;
		iSUsiAdrs   = '0;
		iMUsiRd     = '0;
		iMUfiRd     = '0;
		iMUfiAdrs   = '0;
		iMUfiRdy    = 1'b0;
		iHostWd     = '0;
		iHostWdEn   = 1'b0;
		iHostAdrsEn = 1'b0;
		rngState    = 32'd88;
		repeat (4) @(posedge iSCLK);
		iSRST <= 1'b0;

		errBefore = errCnt;
		hostPortTest();
		reportTest(1, "reset and host port", errBefore);
		errBefore = errCnt;
		regAccessTest();
		reportTest(2, "register access", errBefore);
		errBefore = errCnt;
		cacheOrderTest();
		reportTest(3, "cache order and one-shot", errBefore);
		errBefore = errCnt;
		backPressureTest();
		reportTest(4, "back-pressure pause", errBefore);
		errBefore = errCnt;
		fullTest();
		reportTest(5, "cache full", errBefore);
		errBefore = errCnt;
		ufiCaptureTest();
		reportTest(6, "UFI read capture", errBefore);

		$display("Tests failed %0d of 6, checks %0d, errors %0d", testFails, checkCnt, errCnt);
		if (errCnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== MicroControllerBlock.sv ====
/*
 * System management block
 * CSR slave, cache memory bridge to the UFI bus and host-driven USI master
 */
`timescale 1ns/100ps

module MicroControllerBlock (
	input  logic              iSCLK,
	input  logic              iSRST,
	// USI slave
	input  McbPkg::usiWord_t  iSUsiWd,
	input  McbPkg::usiWord_t  iSUsiAdrs,
	output McbPkg::usiWord_t  oSUsiRd,
	// USI master
	input  McbPkg::usiWord_t  iMUsiRd,
	output McbPkg::usiWord_t  oMUsiWd,
	output McbPkg::usiWord_t  oMUsiAdrs,
	// UFI master
	input  McbPkg::ufiDq_t    iMUfiRd,
	input  McbPkg::ufiAdrs_t  iMUfiAdrs,
	output McbPkg::ufiDq_t    oMUfiWd,
	output McbPkg::ufiAdrs_t  oMUfiAdrs,
	input  logic              iMUfiRdy,
	// Host
	input  McbPkg::usiWord_t  iHostWd,
	input  logic              iHostWdEn,
	input  logic              iHostAdrsEn,
	output McbPkg::usiWord_t  oHostRd
);

	McbPkg::ufiDq_t     wRamWd;
	McbPkg::cacheAdrs_t wRamAdrs;
	logic               wRamEn;
	logic               wRamFull, wRamEmp;
	McbPkg::ufiDq_t     wUfiRd;
	logic               wUfiRdVd;

	MicroControllerCsr MicroControllerCsr_i (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.iSUsiWd   (iSUsiWd),
		.iSUsiAdrs (iSUsiAdrs),
		.oSUsiRd   (oSUsiRd),
		.oRamWd    (wRamWd),
		.oRamAdrs  (wRamAdrs),
		.oRamEn    (wRamEn),
		.iRamFull  (wRamFull),
		.iRamEmp   (wRamEmp),
		.iRamRd    (wUfiRd),
		.iRamRdVd  (wUfiRdVd)
	);

	UfiBridge UfiBridge_i (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.iRamWd    (wRamWd),
		.iRamAdrs  (wRamAdrs),
		.iRamEn    (wRamEn),
		.oRamFull  (wRamFull),
		.oRamEmp   (wRamEmp),
		.oUfiRd    (wUfiRd),
		.oUfiRdVd  (wUfiRdVd),
		.oMUfiWd   (oMUfiWd),
		.oMUfiAdrs (oMUfiAdrs),
		.iMUfiRdy  (iMUfiRdy),
		.iMUfiRd   (iMUfiRd),
		.iMUfiAdrs (iMUfiAdrs)
	);

	UsiMasterPort UsiMasterPort_i (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.iHostWd     (iHostWd),
		.iHostWdEn   (iHostWdEn),
		.iHostAdrsEn (iHostAdrsEn),
		.oMUsiWd     (oMUsiWd),
		.oMUsiAdrs   (oMUsiAdrs)
	);

	// Host reads the USI master bus directly
	assign oHostRd = iMUsiRd;

endmodule

// ==== MicroControllerCsr.sv ====
/*
 * MCB register file
 * USI slave that decodes the block address, holds the cache write
 * registers and reports FIFO status and captured UFI reads
 */
`timescale 1ns/100ps

module MicroControllerCsr (
	input  logic                   iSCLK,
	input  logic                   iSRST,
	// USI slave
	input  McbPkg::usiWord_t       iSUsiWd,
	input  McbPkg::usiWord_t       iSUsiAdrs,
	output McbPkg::usiWord_t       oSUsiRd,
	// Cache write registers
	output McbPkg::ufiDq_t         oRamWd,
	output McbPkg::cacheAdrs_t     oRamAdrs,
	output logic                   oRamEn,
	// Status and UFI capture
	input  logic                   iRamFull,
	input  logic                   iRamEmp,
	input  McbPkg::ufiDq_t         iRamRd,
	input  logic                   iRamRdVd
);

	//------------------------------------------------------------
	// Address decode
	//------------------------------------------------------------
	logic               qAccess;
	McbPkg::csrAdrs_t   qCsrAdrs;

	always_comb
	begin
		qAccess  = (iSUsiAdrs[31:24] == McbPkg::McbBlockAdrs);
		qCsrAdrs = iSUsiAdrs[McbPkg::McbCsrAdrsWidth-1:0];
	end

	//------------------------------------------------------------
	// Writable registers
	//------------------------------------------------------------
	McbPkg::ufiDq_t     rRamWd, qRamWdNext;
	McbPkg::cacheAdrs_t rRamAdrs, qRamAdrsNext;
	logic               rRamEn, qRamEnNext;
	logic [15:0]        rUfiRdCnt;

	// Next values also feed the read mux so a write reads back at once
	always_comb
	begin
		qRamWdNext   = rRamWd;
		qRamAdrsNext = rRamAdrs;
		qRamEnNext   = rRamEn;
		if (qAccess)
		begin
			case (qCsrAdrs)
				McbPkg::CsrRamWd:   qRamWdNext   = iSUsiWd[McbPkg::McbUfiDqWidth-1:0];
				McbPkg::CsrRamAdrs: qRamAdrsNext = iSUsiWd[McbPkg::McbCacheAdrsWidth-1:0];
				McbPkg::CsrRamEn:   qRamEnNext   = iSUsiWd[0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rRamWd   <= '0;
			rRamAdrs <= '0;
			rRamEn   <= 1'b0;
		end
		else
		begin
			rRamWd   <= qRamWdNext;
			rRamAdrs <= qRamAdrsNext;
			rRamEn   <= qRamEnNext;
		end
	end

	// Count of UFI reads captured for this block
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rUfiRdCnt <= '0;
		else if (iRamRdVd)
			rUfiRdCnt <= rUfiRdCnt + 16'd1;
	end

	//------------------------------------------------------------
	// Read mux
	//------------------------------------------------------------
	McbPkg::usiWord_t   qRdMux;
	McbPkg::usiWord_t   rSUsiRd;

	always_comb
	begin
		case (qCsrAdrs)
			McbPkg::CsrRamWd:    qRdMux = {16'd0, qRamWdNext};
			McbPkg::CsrRamAdrs:  qRdMux = {1'b0, qRamAdrsNext};
			McbPkg::CsrRamEn:    qRdMux = {31'd0, qRamEnNext};
			McbPkg::CsrStatus:   qRdMux = {30'd0, iRamEmp, iRamFull};
			McbPkg::CsrUfiRd:    qRdMux = {16'd0, iRamRd};
			McbPkg::CsrUfiRdCnt: qRdMux = {16'd0, rUfiRdCnt};
			default:             qRdMux = '0;
		endcase
	end

	// Holds until the next access to this block
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rSUsiRd <= '0;
		else if (qAccess)
			rSUsiRd <= qRdMux;
	end

	assign oSUsiRd  = rSUsiRd;
	assign oRamWd   = rRamWd;
	assign oRamAdrs = rRamAdrs;
	assign oRamEn   = rRamEn;

endmodule

// ==== UsiMasterPort.sv ====
/*
 * USI master port
 * Turns host write strobes into a held write data word and a
 * one-cycle address pulse
 */
`timescale 1ns/100ps

module UsiMasterPort (
	input  logic              iSCLK,
	input  logic              iSRST,
	input  McbPkg::usiWord_t  iHostWd,
	input  logic              iHostWdEn,
	input  logic              iHostAdrsEn,
	output McbPkg::usiWord_t  oMUsiWd,
	output McbPkg::usiWord_t  oMUsiAdrs
);

	McbPkg::usiWord_t rMUsiWd;
	McbPkg::usiWord_t rMUsiAdrs;

	//------------------------------------------------------------
	// Write data
	//------------------------------------------------------------
	// Keeps the last strobed word
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rMUsiWd <= '0;
		else if (iHostWdEn)
			rMUsiWd <= iHostWd;
	end

	//------------------------------------------------------------
	// Address pulse
	//------------------------------------------------------------
	// Zero address means an idle bus, so it falls back after one cycle
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rMUsiAdrs <= '0;
		else if (iHostAdrsEn)
			rMUsiAdrs <= iHostWd;
		else
			rMUsiAdrs <= '0;
	end

	assign oMUsiWd   = rMUsiWd;
	assign oMUsiAdrs = rMUsiAdrs;

endmodule

// ==== UfiBridge.sv ====
/*
 * UFI bridge
 * Loads the cache FIFO from the CSR write registers, drains it onto the
 * UFI master bus and captures UFI reads addressed to this block
 */
`timescale 1ns/100ps

module UfiBridge (
	input  logic                iSCLK,
	input  logic                iSRST,
	// From the CSR
	input  McbPkg::ufiDq_t      iRamWd,
	input  McbPkg::cacheAdrs_t  iRamAdrs,
	input  logic                iRamEn,
	output logic                oRamFull,
	output logic                oRamEmp,
	output McbPkg::ufiDq_t      oUfiRd,
	output logic                oUfiRdVd,
	// UFI master
	output McbPkg::ufiDq_t      oMUfiWd,
	output McbPkg::ufiAdrs_t    oMUfiAdrs,
	input  logic                iMUfiRdy,
	input  McbPkg::ufiDq_t      iMUfiRd,
	input  McbPkg::ufiAdrs_t    iMUfiAdrs
);

	//------------------------------------------------------------
	// Cache write one-shot
	//------------------------------------------------------------
	logic                rRamEnArmed;
	logic                qMcmWe, qMcmRe;
	McbPkg::cacheEntry_t qMcmWd;
	McbPkg::cacheEntry_t wMcmRd;
	logic                wMcmFull, wMcmEmp, wMcmRvd;

	// Armed once the enable has been seen low
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rRamEnArmed <= 1'b0;
		else
			rRamEnArmed <= ~iRamEn;
	end

	always_comb
	begin
		qMcmWd = {1'b0, iRamAdrs, iRamWd};
		qMcmWe = iRamEn & rRamEnArmed & ~wMcmFull;
		// Ready level is the only back-pressure
		qMcmRe = iMUfiRdy & ~wMcmEmp;
	end

	SyncFifoController #(
		.pFifoDepth    (McbPkg::McbCacheDepth),
		.pFifoBitWidth (McbPkg::McbCacheWidth)
	) McbCacheMemory (
		.iCLK  (iSCLK),
		.iSRST (iSRST),
		.iWd   (qMcmWd),
		.iWe   (qMcmWe),
		.oFull (wMcmFull),
		.oRd   (wMcmRd),
		.iRe   (qMcmRe),
		.oRvd  (wMcmRvd),
		.oEmp  (wMcmEmp)
	);

	assign oRamFull  = wMcmFull;
	assign oRamEmp   = wMcmEmp;
	assign oMUfiWd   = wMcmRd[McbPkg::McbUfiDqWidth-1:0];
	assign oMUfiAdrs = {wMcmRvd, wMcmRd[McbPkg::McbUfiDqWidth +: McbPkg::McbCacheAdrsWidth]};

	//------------------------------------------------------------
	// UFI read capture
	//------------------------------------------------------------
	logic           qUfiRdCke;
	McbPkg::ufiDq_t rUfiRd;

	always_comb
	begin
		qUfiRdCke = iMUfiAdrs[McbPkg::McbUfiAdrsWidth-1]
			& (iMUfiAdrs[28:25] == McbPkg::McbUfiAdrsMap);
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rUfiRd <= '0;
		else if (qUfiRdCke)
			rUfiRd <= iMUfiRd;
	end

	assign oUfiRd   = rUfiRd;
	assign oUfiRdVd = qUfiRdCke;

endmodule

// ==== SyncFifoController.sv ====
/*
 * Synchronous FIFO
 * Circular buffer with registered read data, a read-valid pulse and
 * full and empty flags registered from the entry count
 */
`timescale 1ns/100ps

module SyncFifoController #(
	parameter int pFifoDepth    = 512,
	parameter int pFifoBitWidth = 48
)(
	input  logic                     iCLK,
	input  logic                     iSRST,
	input  logic [pFifoBitWidth-1:0] iWd,
	input  logic                     iWe,
	output logic                     oFull,
	output logic [pFifoBitWidth-1:0] oRd,
	input  logic                     iRe,
	output logic                     oRvd,
	output logic                     oEmp
);

	localparam int lpPtrWidth = $clog2(pFifoDepth);
	localparam int lpCntWidth = $clog2(pFifoDepth + 1);

	logic [pFifoBitWidth-1:0] rMem [0:pFifoDepth-1];
	logic [lpPtrWidth-1:0]    rWp, rRp;
	logic [lpCntWidth-1:0]    rCnt, qCntNext;
	logic                     rFull, rEmp;
	logic [pFifoBitWidth-1:0] rRd;
	logic                     rRvd;
	logic                     qWe, qRe;

	// Accesses past the flags are dropped
	always_comb
	begin
		qWe = iWe & ~rFull;
		qRe = iRe & ~rEmp;
		case ({qWe, qRe})
			2'b10:   qCntNext = rCnt + 1'b1;
			2'b01:   qCntNext = rCnt - 1'b1;
			default: qCntNext = rCnt;
		endcase
	end

	always_ff @(posedge iCLK)
	begin
		if (qWe)
			rMem[rWp] <= iWd;
	end

	//------------------------------------------------------------
	// Pointers, count and flags
	//------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iSRST)
		begin
			rWp   <= '0;
			rRp   <= '0;
			rCnt  <= '0;
			rFull <= 1'b0;
			rEmp  <= 1'b1;
		end
		else
		begin
			if (qWe)
				rWp <= (rWp == lpPtrWidth'(pFifoDepth - 1)) ? '0 : rWp + 1'b1;
			if (qRe)
				rRp <= (rRp == lpPtrWidth'(pFifoDepth - 1)) ? '0 : rRp + 1'b1;
			rCnt  <= qCntNext;
			rFull <= (qCntNext == lpCntWidth'(pFifoDepth));
			rEmp  <= (qCntNext == '0);
		end
	end

	// Read port, data and valid arrive together
	always_ff @(posedge iCLK)
	begin
		if (iSRST)
		begin
			rRd  <= '0;
			rRvd <= 1'b0;
		end
		else
		begin
			if (qRe)
				rRd <= rMem[rRp];
			rRvd <= qRe;
		end
	end

	assign oFull = rFull;
	assign oEmp  = rEmp;
	assign oRd   = rRd;
	assign oRvd  = rRvd;

endmodule

// ==== McbPkg.sv ====
/*
 * MCB shared definitions
 * Bus widths, address maps, CSR offsets and the cache memory geometry
 * of the system management block
 */
package McbPkg;

	//------------------------------------------------------------
	// Bus widths
	//------------------------------------------------------------
	localparam int McbUsiWidth     = 32;
	localparam int McbUfiDqWidth   = 16;
	localparam int McbUfiAdrsWidth = 32;
	localparam int McbCsrAdrsWidth = 8;

	typedef logic [McbUsiWidth-1:0]     usiWord_t;
	typedef logic [McbUfiDqWidth-1:0]   ufiDq_t;
	typedef logic [McbUfiAdrsWidth-1:0] ufiAdrs_t;
	typedef logic [McbCsrAdrsWidth-1:0] csrAdrs_t;

	//------------------------------------------------------------
	// Address maps
	//------------------------------------------------------------
	// USI address bits 31:24 that select this block
	localparam logic [7:0] McbBlockAdrs = 8'h01;

	// UFI address bits 28:25 of a read aimed at this block
	localparam logic [3:0] McbUfiAdrsMap = 4'h0;

	//------------------------------------------------------------
	// Cache memory
	//------------------------------------------------------------
	localparam int McbCacheDepth     = 512;
	localparam int McbCacheWidth     = 48;

	// Address field carried alongside the data, bit 31 is the valid bit
	localparam int McbCacheAdrsWidth = McbUfiAdrsWidth - 1;

	typedef logic [McbCacheAdrsWidth-1:0] cacheAdrs_t;

	// Top bit spare, then 31 address bits above 16 data bits
	typedef logic [McbCacheWidth-1:0] cacheEntry_t;

	//------------------------------------------------------------
	// CSR offsets
	//------------------------------------------------------------
	localparam csrAdrs_t CsrRamWd    = 8'h00;
	localparam csrAdrs_t CsrRamAdrs  = 8'h04;
	localparam csrAdrs_t CsrRamEn    = 8'h08;
	// bit 0 full, bit 1 empty
	localparam csrAdrs_t CsrStatus   = 8'h0C;
	localparam csrAdrs_t CsrUfiRd    = 8'h10;
	localparam csrAdrs_t CsrUfiRdCnt = 8'h14;

endpackage
